// ==== icache.f ====
logic/icache_pkg.sv
logic/mem_bus_pkg.sv
logic/icache_tag_array.sv
logic/icache_data_array.sv
logic/icache_plru.sv
logic/icache_ctrl.sv
logic/icache_top.sv
verif/icache_props.sv
verif/icache_tb.sv

// ==== logic/icache_ctrl.sv ====
module icache_ctrl (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  inst_req,
    input  mem_bus_pkg::addr_t    inst_addr,
    output logic                  inst_data_ok,
    output icache_pkg::word_t     inst_rdata,
    input  logic                  hit,
    input  icache_pkg::word_t     hit_word,
    input  icache_pkg::way_t      victim,
    output logic                  lookup_en,
    output logic                  plru_touch,
    output logic                  plru_commit,
    output icache_pkg::set_t      plru_set,
    output logic                  fill_en,
    output icache_pkg::word_sel_t fill_word,
    output icache_pkg::way_t      fill_way,
    output logic                  tag_write,
    output icache_pkg::set_t      held_set,
    output icache_pkg::tag_t      held_tag,
    output logic                  arvalid,
    output mem_bus_pkg::addr_t    araddr,
    output mem_bus_pkg::len_t     arlen,
    output mem_bus_pkg::size_t    arsize,
    output mem_bus_pkg::burst_t   arburst,
    input  logic                  arready,
    input  logic                  rvalid,
    input  icache_pkg::word_t     rdata,
    input  logic                  rlast
);

    localparam int set_lsb = icache_pkg::offset_bits + 2;

    icache_pkg::ctrl_state_t state;
    icache_pkg::ctrl_state_t state_next;

    mem_bus_pkg::addr_t    addr_q;
    mem_bus_pkg::addr_t    phys_addr;
    logic                  cached_q;
    logic                  req_cached;
    logic                  accept;
    icache_pkg::word_sel_t beat_q;
    icache_pkg::word_t     word_q;

    assign req_cached = inst_addr[31:29] != mem_bus_pkg::kseg1_code;

    assign accept = inst_req && (state == icache_pkg::idle
                    || state == icache_pkg::data_ready
                    || (state == icache_pkg::lookup && hit));

    always_comb begin
        state_next = state;
        case (state)
            icache_pkg::idle:          state_next = icache_pkg::idle;
            icache_pkg::lookup:        state_next = hit ? icache_pkg::idle
                                                        : icache_pkg::refill_addr;
            icache_pkg::bypass_addr:   if (arready) state_next = icache_pkg::bypass_data;
            icache_pkg::bypass_data:   if (rvalid) state_next = icache_pkg::data_ready;
            icache_pkg::refill_addr:   if (arready) state_next = icache_pkg::refill_data;
            icache_pkg::refill_data:   if (rvalid && rlast) state_next = icache_pkg::refill_commit;
            icache_pkg::refill_commit: state_next = icache_pkg::data_ready;
            icache_pkg::data_ready:    state_next = icache_pkg::idle;
            default:                   state_next = icache_pkg::idle;
        endcase
        // a new request overrides the return to idle
        if (accept) begin
            state_next = req_cached ? icache_pkg::lookup : icache_pkg::bypass_addr;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state  <= icache_pkg::idle;
            beat_q <= '0;
        end else begin
            state <= state_next;
            if (fill_en) begin
                beat_q <= beat_q + icache_pkg::word_sel_t'(1);
            end else if (state != icache_pkg::refill_data) begin
                beat_q <= '0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            addr_q   <= inst_addr;
            cached_q <= req_cached;
        end
        // victim fixed for the whole refill
        if (state == icache_pkg::lookup && !hit) begin
            fill_way <= victim;
        end
        if (state == icache_pkg::bypass_data && rvalid) begin
            word_q <= rdata;
        end else if (fill_en && beat_q == addr_q[2 +: icache_pkg::offset_bits]) begin
            word_q <= rdata;
        end
    end

    // kseg0 and kseg1 both map to the low physical window
    assign phys_addr = (addr_q[31:29] == mem_bus_pkg::kseg0_code
                        || addr_q[31:29] == mem_bus_pkg::kseg1_code)
                       ? {3'b000, addr_q[28:0]} : addr_q;

    assign held_set = addr_q[set_lsb +: icache_pkg::index_bits];
    assign held_tag = addr_q[31 -: icache_pkg::tag_bits];
    assign plru_set = addr_q[set_lsb +: icache_pkg::index_bits];

    assign lookup_en   = accept && req_cached;
    assign plru_touch  = state == icache_pkg::lookup && hit;
    assign plru_commit = state == icache_pkg::refill_commit;
    assign tag_write   = state == icache_pkg::refill_commit;
    assign fill_en     = state == icache_pkg::refill_data && rvalid;
    assign fill_word   = beat_q;

    assign inst_data_ok = state == icache_pkg::data_ready || (state == icache_pkg::lookup && hit);
    assign inst_rdata   = (state == icache_pkg::data_ready) ? word_q : hit_word;

    assign arvalid = state == icache_pkg::refill_addr || state == icache_pkg::bypass_addr;
    // refill starts at the 32-byte line boundary
    assign araddr  = cached_q ? {phys_addr[mem_bus_pkg::addr_bits-1:set_lsb], 5'b00000}
                              : phys_addr;
    assign arlen   = cached_q ? mem_bus_pkg::refill_len : mem_bus_pkg::single_len;
    assign arsize  = mem_bus_pkg::beat_size;
    assign arburst = cached_q ? mem_bus_pkg::burst_incr : mem_bus_pkg::burst_fixed;

endmodule

// ==== logic/icache_data_array.sv ====
module icache_data_array (
    input  logic                  clk,
    input  logic                  read_en,
    input  icache_pkg::set_t      read_set,
    input  icache_pkg::word_sel_t read_word,
    input  icache_pkg::way_t      read_way,
    input  logic                  write_en,
    input  icache_pkg::way_t      write_way,
    input  icache_pkg::set_t      write_set,
    input  icache_pkg::word_sel_t write_word,
    input  icache_pkg::word_t     write_data,
    output icache_pkg::word_t     rdata
);

    icache_pkg::word_t mem
        [icache_pkg::num_ways][icache_pkg::num_sets * icache_pkg::words_per_line];

    // one word per way, read in parallel with the tag compare
    icache_pkg::word_t way_q [icache_pkg::num_ways];

    always_ff @(posedge clk) begin
        if (write_en) begin
            mem[write_way][{write_set, write_word}] <= write_data;
        end
        if (read_en) begin
            for (int w = 0; w < icache_pkg::num_ways; w++) begin
                way_q[w] <= mem[w][{read_set, read_word}];
            end
        end
    end

    // way is known only after the compare
    assign rdata = way_q[read_way];

endmodule

// ==== logic/icache_pkg.sv ====
package icache_pkg;

    // cache geometry
    localparam int num_ways       = 4;
    localparam int num_sets       = 128;
    localparam int words_per_line = 8;

    // address fields: tag 31:12, index 11:5, word 4:2
    localparam int offset_bits = 3;
    localparam int index_bits  = 7;
    localparam int tag_bits    = 20;

    typedef logic [1:0]             way_t;
    typedef logic [index_bits-1:0]  set_t;
    typedef logic [tag_bits-1:0]    tag_t;
    typedef logic [offset_bits-1:0] word_sel_t;
    typedef logic [31:0]            word_t;

    typedef enum logic [2:0] {
        idle,
        lookup,
        bypass_addr,
        bypass_data,
        refill_addr,
        refill_data,
        refill_commit,
        data_ready
    } ctrl_state_t;

endpackage

// ==== logic/icache_plru.sv ====
module icache_plru (
    input  logic             clk,
    input  logic             rst,
    input  icache_pkg::set_t set,
    input  logic             touch_en,
    input  icache_pkg::way_t touch_way,
    input  logic             commit_en,
    output icache_pkg::way_t victim
);

    logic [icache_pkg::num_sets-1:0]      root;
    logic [1:0][icache_pkg::num_sets-1:0] pair;

    logic             upd_en;
    icache_pkg::way_t upd_way;

    // root picks the pair, pair bit picks the way inside it
    assign victim = root[set] ? {1'b1, pair[1][set]} : {1'b0, pair[0][set]};

    // a commit retires the current victim just like a touch would
    assign upd_en  = touch_en || commit_en;
    assign upd_way = touch_en ? touch_way : victim;

    always_ff @(posedge clk) begin
        if (rst) begin
            root <= '0;
            pair <= '0;
        end else if (upd_en) begin
            root[set]             <= ~upd_way[1];
            pair[upd_way[1]][set] <= ~upd_way[0];
        end
    end

endmodule

// ==== logic/icache_tag_array.sv ====
module icache_tag_array (
    input  logic             clk,
    input  logic             rst,
    input  logic             lookup_en,
    input  icache_pkg::set_t lookup_set,
    input  icache_pkg::tag_t lookup_tag,
    input  logic             write_en,
    input  icache_pkg::way_t write_way,
    input  icache_pkg::set_t write_set,
    input  icache_pkg::tag_t write_tag,
    output logic             hit,
    output icache_pkg::way_t hit_way
);

    icache_pkg::tag_t tags [icache_pkg::num_ways][icache_pkg::num_sets];
    logic [icache_pkg::num_ways-1:0][icache_pkg::num_sets-1:0] valid;

    icache_pkg::set_t set_q;
    icache_pkg::tag_t tag_q;
    logic [icache_pkg::num_ways-1:0] way_match;

    always_ff @(posedge clk) begin
        if (rst) begin
            valid <= '0;
        end else if (write_en) begin
            valid[write_way][write_set] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (write_en) begin
            tags[write_way][write_set] <= write_tag;
        end
        if (lookup_en) begin
            set_q <= lookup_set;
            tag_q <= lookup_tag;
        end
    end

    // compare all ways, lowest hitting way wins
    always_comb begin
        hit_way = '0;
        for (int w = icache_pkg::num_ways - 1; w >= 0; w--) begin
            way_match[w] = valid[w][set_q] && (tags[w][set_q] == tag_q);
            if (way_match[w]) begin
                hit_way = icache_pkg::way_t'(w);
            end
        end
        hit = |way_match;
    end

endmodule

// ==== logic/icache_top.sv ====
module icache_top (
    input  logic                clk,
    input  logic                rst,
    input  logic                inst_req,
    input  mem_bus_pkg::addr_t  inst_addr,
    output logic                inst_data_ok,
    output icache_pkg::word_t   inst_rdata,
    output logic                arvalid,
    output mem_bus_pkg::addr_t  araddr,
    output mem_bus_pkg::len_t   arlen,
    output mem_bus_pkg::size_t  arsize,
    output mem_bus_pkg::burst_t arburst,
    input  logic                arready,
    input  logic                rvalid,
    input  icache_pkg::word_t   rdata,
    input  logic                rlast,
    output logic                rready
);

    logic                  hit;
    icache_pkg::way_t      hit_way;
    icache_pkg::word_t     hit_word;
    icache_pkg::way_t      victim;
    logic                  lookup_en;
    logic                  plru_touch;
    logic                  plru_commit;
    icache_pkg::set_t      plru_set;
    logic                  fill_en;
    icache_pkg::word_sel_t fill_word;
    icache_pkg::way_t      fill_way;
    logic                  tag_write;
    icache_pkg::set_t      held_set;
    icache_pkg::tag_t      held_tag;

    // data beats are never stalled
    assign rready = 1'b1;

    icache_ctrl u_ctrl (
        .clk(clk), .rst(rst),
        .inst_req(inst_req), .inst_addr(inst_addr),
        .inst_data_ok(inst_data_ok), .inst_rdata(inst_rdata),
        .hit(hit), .hit_word(hit_word), .victim(victim),
        .lookup_en(lookup_en), .plru_touch(plru_touch), .plru_commit(plru_commit),
        .plru_set(plru_set), .fill_en(fill_en), .fill_word(fill_word), .fill_way(fill_way),
        .tag_write(tag_write), .held_set(held_set), .held_tag(held_tag),
        .arvalid(arvalid), .araddr(araddr), .arlen(arlen), .arsize(arsize),
        .arburst(arburst), .arready(arready),
        .rvalid(rvalid), .rdata(rdata), .rlast(rlast)
    );

    icache_tag_array u_tags (
        .clk(clk), .rst(rst),
        .lookup_en(lookup_en),
        .lookup_set(inst_addr[icache_pkg::offset_bits + 2 +: icache_pkg::index_bits]),
        .lookup_tag(inst_addr[31 -: icache_pkg::tag_bits]),
        .write_en(tag_write), .write_way(fill_way), .write_set(held_set),
        .write_tag(held_tag), .hit(hit), .hit_way(hit_way)
    );

    icache_data_array u_data (
        .clk(clk),
        .read_en(lookup_en),
        .read_set(inst_addr[icache_pkg::offset_bits + 2 +: icache_pkg::index_bits]),
        .read_word(inst_addr[2 +: icache_pkg::offset_bits]),
        .read_way(hit_way),
        .write_en(fill_en), .write_way(fill_way), .write_set(held_set),
        .write_word(fill_word), .write_data(rdata), .rdata(hit_word)
    );

    icache_plru u_plru (
        .clk(clk), .rst(rst), .set(plru_set),
        .touch_en(plru_touch), .touch_way(hit_way),
        .commit_en(plru_commit), .victim(victim)
    );

endmodule

// ==== logic/mem_bus_pkg.sv ====
package mem_bus_pkg;

    localparam int addr_bits = 32;

    typedef logic [addr_bits-1:0] addr_t;
    typedef logic [7:0]           len_t;
    typedef logic [2:0]           size_t;
    typedef logic [1:0]           burst_t;

    localparam len_t   refill_len  = 8'd7;
    localparam len_t   single_len  = 8'd0;
    localparam size_t  beat_size   = 3'd2;
    localparam burst_t burst_incr  = 2'd1;
    localparam burst_t burst_fixed = 2'd0;

    // window codes in the top three address bits
    localparam logic [2:0] kseg0_code = 3'b100;
    localparam logic [2:0] kseg1_code = 3'b101;

endpackage

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build with Verilator, run, and look for the pass line in the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/1ps -f icache.f \
    --top-module icache_tb -o icache_sim > build.log 2>&1 \
    && ./obj_dir/icache_sim > sim.log 2>&1 \
    ; cat sim.log \
    && grep -qx "all tests passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

// ==== verif/icache_cases.txt ====
// fetch address in hex, then 1 when the fetch has to go to the bus
// cold miss in the middle of a line, then hits in the same line
80000014 1
80000000 0
8000001c 0
// uncached window is never allocated
a0000208 1
a0000208 1
// address outside both windows
00000300 1
00000304 0
// five tags in set 5
800100a4 1
800200a8 1
800300ac 1
800400b0 1
800100a0 0
800500b4 1
800100bc 0
800200a8 1
800300b0 0
800400b0 1
800500b4 1
800100a4 1
// one physical line seen through three windows
00001018 1
00001004 0
a0001018 1
80001010 1
8000101c 0

// ==== verif/icache_props.sv ====
module icache_props (
    input logic                clk,
    input logic                rst,
    input logic                inst_data_ok,
    input logic                arvalid,
    input mem_bus_pkg::addr_t  araddr,
    input mem_bus_pkg::len_t   arlen,
    input mem_bus_pkg::size_t  arsize,
    input mem_bus_pkg::burst_t arburst,
    input logic                arready,
    input logic                rvalid,
    input logic                rlast
);
    timeunit 1ns;
    timeprecision 1ps;

    int violations = 0;

    // read accepted on the bus, last beat not yet seen
    logic read_busy;

    always_ff @(posedge clk) begin
        if (rst) begin
            read_busy <= 1'b0;
        end else if (arvalid && arready) begin
            read_busy <= 1'b1;
        end else if (rvalid && rlast) begin
            read_busy <= 1'b0;
        end
    end

    // request held until the slave takes it
    ar_stable: assert property (@(posedge clk) disable iff (rst)
        arvalid && !arready |=> arvalid && $stable(araddr) && $stable(arlen)
            && $stable(arsize) && $stable(arburst))
        else begin
            violations++;
            $error("address channel changed before arready");
        end

    no_ok_during_read: assert property (@(posedge clk) disable iff (rst)
        !(inst_data_ok && (arvalid || read_busy)))
        else begin
            violations++;
            $error("inst_data_ok while a bus read is still open");
        end

    rlast_with_rvalid: assert property (@(posedge clk) disable iff (rst)
        rlast |-> rvalid)
        else begin
            violations++;
            $error("rlast without rvalid");
        end

endmodule

bind icache_top icache_props u_props (
    .clk(clk), .rst(rst), .inst_data_ok(inst_data_ok),
    .arvalid(arvalid), .araddr(araddr), .arlen(arlen), .arsize(arsize),
    .arburst(arburst), .arready(arready), .rvalid(rvalid), .rlast(rlast)
);

// ==== verif/icache_tb.sv ====
module icache_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam icache_pkg::word_t data_key = 32'h1357_9bdf;
    localparam int fetch_timeout = 300;
    localparam int max_cases     = 64;

    logic                clk;
    logic                rst;
    logic                inst_req;
    mem_bus_pkg::addr_t  inst_addr;
    logic                inst_data_ok;
    icache_pkg::word_t   inst_rdata;
    logic                arvalid;
    mem_bus_pkg::addr_t  araddr;
    mem_bus_pkg::len_t   arlen;
    mem_bus_pkg::size_t  arsize;
    mem_bus_pkg::burst_t arburst;
    logic                arready;
    logic                rvalid;
    icache_pkg::word_t   rdata;
    logic                rlast;
    logic                rready;

    // memory slave: 0 idle, 1 address wait, 2 data beats
    int                 bus_phase;
    int                 ar_delay;
    int                 beat;
    int                 bus_reads;
    mem_bus_pkg::addr_t ar_addr;
    mem_bus_pkg::len_t  ar_len;
    string              cur_name;
    mem_bus_pkg::addr_t cur_addr;

    // reference contents, tree bits are root, pair 1, pair 0
    icache_pkg::tag_t                model_tag [icache_pkg::num_ways][icache_pkg::num_sets];
    logic [icache_pkg::num_ways-1:0] model_valid [icache_pkg::num_sets];
    logic [2:0]                      model_tree [icache_pkg::num_sets];

    // address and flag pairs
    logic [31:0] cases_mem [2*max_cases];

    icache_top UUT (
        .clk(clk), .rst(rst), .inst_req(inst_req), .inst_addr(inst_addr),
        .inst_data_ok(inst_data_ok), .inst_rdata(inst_rdata),
        .arvalid(arvalid), .araddr(araddr), .arlen(arlen), .arsize(arsize),
        .arburst(arburst), .arready(arready), .rvalid(rvalid), .rdata(rdata),
        .rlast(rlast), .rready(rready)
    );

    always #10 clk = ~clk;

    task automatic abort_run();
        $display("tests failed");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_word(input string name, input icache_pkg::word_t exp,
                              input icache_pkg::word_t act);
        if (act !== exp) begin
            $display("mismatch in %s: expected %h, actual %h", name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_addr(input string name, input mem_bus_pkg::addr_t exp,
                              input mem_bus_pkg::addr_t act);
        if (act !== exp) begin
            $display("mismatch in %s araddr: expected %h, actual %h", name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_len(input string name, input mem_bus_pkg::len_t exp,
                             input mem_bus_pkg::len_t act);
        if (act !== exp) begin
            $display("mismatch in %s arlen: expected %0d, actual %0d", name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_size(input string name, input mem_bus_pkg::size_t exp,
                              input mem_bus_pkg::size_t act);
        if (act !== exp) begin
            $display("mismatch in %s arsize: expected %0d, actual %0d", name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_burst(input string name, input mem_bus_pkg::burst_t exp,
                               input mem_bus_pkg::burst_t act);
        if (act !== exp) begin
            $display("mismatch in %s arburst: expected %0d, actual %0d", name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("mismatch in %s: expected %b, actual %b", name, exp, act);
            abort_run();
        end
    endtask

    function automatic mem_bus_pkg::addr_t phys_of(input mem_bus_pkg::addr_t a);
        if (a[31:29] == mem_bus_pkg::kseg0_code || a[31:29] == mem_bus_pkg::kseg1_code) begin
            return {3'b000, a[28:0]};
        end
        return a;
    endfunction

    task automatic predict_read(input mem_bus_pkg::addr_t a, output logic read);
        icache_pkg::set_t s;
        icache_pkg::tag_t t;
        icache_pkg::way_t w;
        logic             found;
        s = a[icache_pkg::offset_bits + 2 +: icache_pkg::index_bits];
        t = a[31 -: icache_pkg::tag_bits];
        found = 1'b0;
        w = '0;
        for (int i = icache_pkg::num_ways - 1; i >= 0; i--) begin
            if (model_valid[s][i] && model_tag[i][s] == t) begin
                found = 1'b1;
                w = icache_pkg::way_t'(i);
            end
        end
        if (!found) begin
            w = model_tree[s][2] ? {1'b1, model_tree[s][1]} : {1'b0, model_tree[s][0]};
            model_valid[s][w] = 1'b1;
            model_tag[w][s] = t;
        end
        // point the tree away from the way just used
        model_tree[s][2] = ~w[1];
        model_tree[s][w[1]] = ~w[0];
        read = !found;
    endtask

    // one falling edge of the memory slave
    task automatic bus_step();
        logic bypass;
        arready = 1'b0;
        rvalid = 1'b0;
        rlast = 1'b0;
        if (bus_phase == 2) begin
            if ($urandom % 3 != 0) begin
                check_flag({cur_name, " rready"}, 1'b1, rready);
                rvalid = 1'b1;
                rdata = (ar_addr + 32'(beat * 4)) ^ data_key;
                rlast = beat == int'(ar_len);
                if (rlast) begin
                    bus_phase = 0;
                end else begin
                    beat++;
                end
            end
        end else begin
            if (bus_phase == 0 && arvalid) begin
                bypass = cur_addr[31:29] == mem_bus_pkg::kseg1_code;
                bus_reads++;
                check_addr(cur_name, bypass ? phys_of(cur_addr) : phys_of(cur_addr) & ~32'h1f,
                           araddr);
                check_len(cur_name, bypass ? mem_bus_pkg::single_len : mem_bus_pkg::refill_len,
                          arlen);
                check_burst(cur_name, bypass ? mem_bus_pkg::burst_fixed : mem_bus_pkg::burst_incr,
                            arburst);
                check_size(cur_name, mem_bus_pkg::beat_size, arsize);
                ar_addr = araddr;
                ar_len = arlen;
                ar_delay = $urandom % 4;
                bus_phase = 1;
            end
            if (bus_phase == 1) begin
                if (ar_delay == 0) begin
                    arready = 1'b1;
                    bus_phase = 2;
                    beat = 0;
                end else begin
                    ar_delay--;
                end
            end
        end
    endtask

    task automatic fetch(input int idx, input mem_bus_pkg::addr_t addr, input logic exp_read);
        int cycles;
        int reads_before;
        @(negedge clk);
        bus_step();
        if (inst_data_ok) begin
            $display("inst_data_ok pulsed again before case %0d was requested", idx);
            abort_run();
        end
        cur_name = $sformatf("case %0d at %h", idx, addr);
        cur_addr = addr;
        reads_before = bus_reads;
        inst_req = 1'b1;
        inst_addr = addr;
        @(negedge clk);
        bus_step();
        inst_req = 1'b0;
        cycles = 1;
        while (!inst_data_ok) begin
            if (cycles >= fetch_timeout) begin
                $display("no inst_data_ok within %0d cycles in %s", fetch_timeout, cur_name);
                abort_run();
            end
            @(negedge clk);
            bus_step();
            cycles++;
        end
        check_word(cur_name, phys_of(addr) ^ data_key, inst_rdata);
        check_flag({cur_name, " bus read"}, exp_read, bus_reads != reads_before);
        if (!exp_read) begin
            check_flag({cur_name, " one cycle hit"}, 1'b1, cycles == 1);
        end
    endtask

    initial begin
        int   n;
        logic predicted;
        void'($urandom(32'h5257_521b));
        clk = 1'b0;
        rst = 1'b1;
        inst_req = 1'b0;
        inst_addr = '0;
        arready = 1'b0;
        rvalid = 1'b0;
        rdata = '0;
        rlast = 1'b0;
        bus_phase = 0;
        ar_delay = 0;
        beat = 0;
        bus_reads = 0;
        for (int s = 0; s < icache_pkg::num_sets; s++) begin
            model_valid[s] = '0;
            model_tree[s] = '0;
        end
        for (int i = 0; i < 2 * max_cases; i++) begin
            cases_mem[i] = 32'hffff_ffff;
        end
        $readmemh("verif/icache_cases.txt", cases_mem);
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        n = 0;
        while (n < max_cases && cases_mem[2*n] != 32'hffff_ffff) begin
            if (cases_mem[2*n][31:29] == mem_bus_pkg::kseg1_code) begin
                predicted = 1'b1;
            end else begin
                predict_read(cases_mem[2*n], predicted);
            end
            if (predicted != cases_mem[2*n+1][0]) begin
                $display("cases file flag disagrees with the pseudo-LRU model at case %0d", n);
                abort_run();
            end
            fetch(n, cases_mem[2*n], predicted);
            n++;
        end
        if (n == 0 || UUT.u_props.violations != 0) begin
            $display("no cases were run or a protocol assertion failed");
            abort_run();
        end else begin
            $display("all tests passed");
            $finish;
        end
    end

endmodule
